// File: include/alu_settings.svh
//**********************************************************************
// Sizing macros for the credit-controlled integer execute stage
// Data width, queue depths and credit counter width
//**********************************************************************

`ifndef ALU_SETTINGS_SVH
`define ALU_SETTINGS_SVH

// Operand and result width
`define ALU_DATA_W 32

// Issue queue entries
// Producer starts out holding this many credits
`define ALU_OP_DEPTH 4

// Result buffer entries
`define ALU_RES_DEPTH 4

// Consumer buffer size, loaded into the output credit counter
`define ALU_RES_CREDITS 4

// Credit counter width, must hold ALU_RES_CREDITS
`define ALU_CREDIT_W 3

`endif

// File: source/alu_op_pkg.sv
//**********************************************************************
// Operation side types
// Operation kind, access size and queued operation record
//**********************************************************************

`default_nettype none

`include "alu_settings.svh"

package alu_op_pkg;

   // Operation kind
   typedef enum logic [4:0] {
      ADD,    // b + a
      ADDC,   // b + a + C
      RSUB,   // b + ~a + 1
      RSUBC,  // b + ~a + C
      CMP,    // Signed compare
      CMPU,   // Unsigned compare
      OR,
      AND,
      XOR,
      ANDN,   // a & ~b
      SRA,    // Shift right, sign fill
      SRC,    // Shift right through carry
      SRL,    // Shift right, zero fill
      SEXT8,
      SEXT16,
      BSRL,   // Barrel shifts by b[4:0]
      BSRA,
      BSLL,
      ADDR    // Load/store address
   } opKindT;

   // Load/store access size
   typedef enum logic [1:0] {
      BYTE,
      HALF,
      WORD
   } accSizeT;

   // One queued operation, 71 bits
   typedef struct packed {
      opKindT                 kind;
      logic [`ALU_DATA_W-1:0] a;
      logic [`ALU_DATA_W-1:0] b;
      accSizeT                size;
   } aluOpT;

endpackage

`default_nettype wire

// File: source/alu_res_pkg.sv
//**********************************************************************
// Result side types
// Byte lane select and result record
//**********************************************************************

`default_nettype none

`include "alu_settings.svh"

package alu_res_pkg;

   // Big-endian lane enables, bit 3 is byte 0
   typedef logic [3:0] byteSelT;

   // One result, 37 bits
   typedef struct packed {
      logic [`ALU_DATA_W-1:0] data;    // Result word
      logic                   carry;   // Carry flag after the operation
      byteSelT                byteSel; // Zero unless ADDR
   } aluResT;

endpackage

`default_nettype wire

// File: source/credit_fifo.sv
//**********************************************************************
// Synchronous FIFO over a register array
// Payload type set by parameter, shared by operation and result queues
//**********************************************************************

`timescale 1ns/1ns
`default_nettype none

module credit_fifo #(
   parameter type payloadT = logic [7:0],
   parameter int  DEPTH    = 4
) (
   input  logic    clk_i,
   input  logic    rst_i,
   input  logic    wrEn_i,
   input  payloadT wrData_i,
   input  logic    rdEn_i,
   output payloadT rdData_o,
   output logic    empty_o,
   output logic    full_o,
   output logic    almostFull_o
);

   localparam int ptrW = (DEPTH > 1) ? $clog2(DEPTH) : 1;
   localparam int cntW = $clog2(DEPTH + 1);

   payloadT         mem [DEPTH];
   logic [ptrW-1:0] wrPtr;
   logic [ptrW-1:0] rdPtr;
   logic [cntW-1:0] count;   // Occupancy
   logic            doWr;
   logic            doRd;

   // Pointer step with wrap for any depth
   function automatic logic [ptrW-1:0] incPtr(input logic [ptrW-1:0] ptr);
      return (ptr == ptrW'(DEPTH - 1)) ? '0 : ptr + ptrW'(1);
   endfunction

   assign doWr = wrEn_i && !full_o;   // Drop on full, upstream credits prevent it
   assign doRd = rdEn_i && !empty_o;

   assign empty_o      = (count == '0);
   assign full_o       = (count == cntW'(DEPTH));
   assign almostFull_o = (count >= cntW'(DEPTH - 1)); // One free slot or fewer

   assign rdData_o = mem[rdPtr];   // Head of queue, read straight from the array

   always_ff @(posedge clk_i) begin
      if (doWr) begin
         mem[wrPtr] <= wrData_i;
      end
   end

   always_ff @(posedge clk_i) begin
      if (rst_i) begin
         wrPtr <= '0;
         rdPtr <= '0;
         count <= '0;
      end else begin
         if (doWr) begin
            wrPtr <= incPtr(wrPtr);
         end
         if (doRd) begin
            rdPtr <= incPtr(rdPtr);
         end
         count <= count + cntW'(doWr) - cntW'(doRd);
      end
   end

endmodule

`default_nettype wire

// File: source/issue_stage.sv
//**********************************************************************
// Input side of the execute stage
// Packs loose operation ports, queues them, returns producer credits
//**********************************************************************

`timescale 1ns/1ns
`default_nettype none

`include "alu_settings.svh"

module issue_stage (
   input  logic                   clk_i,
   input  logic                   rst_i,
   // Producer side
   input  logic                   opValid_i,
   input  alu_op_pkg::opKindT     opKind_i,
   input  logic [`ALU_DATA_W-1:0] opA_i,
   input  logic [`ALU_DATA_W-1:0] opB_i,
   input  alu_op_pkg::accSizeT    opSize_i,
   output logic                   opCredit_o,
   // Toward exec_unit
   output alu_op_pkg::aluOpT      issOp_o,
   output logic                   issValid_o,
   input  logic                   issTake_i
);

   import alu_op_pkg::*;

   aluOpT newOp;      // Packed incoming operation
   logic  queueEmpty;

   assign newOp = '{kind: opKind_i, a: opA_i, b: opB_i, size: opSize_i};

   // Producer only sends with a credit in hand, so no full check here
   credit_fifo #(
      .payloadT (aluOpT),
      .DEPTH    (`ALU_OP_DEPTH)
   ) opQueue (
      .clk_i        (clk_i),
      .rst_i        (rst_i),
      .wrEn_i       (opValid_i),
      .wrData_i     (newOp),
      .rdEn_i       (issTake_i),
      .rdData_o     (issOp_o),
      .empty_o      (queueEmpty),
      .full_o       (),
      .almostFull_o ()
   );

   assign issValid_o = !queueEmpty;   // Visible the cycle after the write

   // One credit back per released slot, set on the take edge
   always_ff @(posedge clk_i) begin
      if (rst_i) begin
         opCredit_o <= 1'b0;
      end else begin
         opCredit_o <= issTake_i;
      end
   end

endmodule

`default_nettype wire

// File: source/exec_unit.sv
//**********************************************************************
// Execute datapath
// Shared adder, compare, logic, single shifts, sign extension,
// barrel shifter, carry flag and load/store byte lanes
// Everything lands in one result register
//**********************************************************************

`timescale 1ns/1ns
`default_nettype none

`include "alu_settings.svh"

module exec_unit (
   input  logic                clk_i,
   input  logic                rst_i,
   input  alu_op_pkg::aluOpT   issOp_i,
   input  logic                issValid_i,
   output logic                issTake_o,
   input  logic                exReady_i,
   output alu_res_pkg::aluResT exRes_o,
   output logic                exValid_o
);

   import alu_op_pkg::*;
   import alu_res_pkg::*;

   localparam int msb    = `ALU_DATA_W - 1;
   localparam int shiftW = $clog2(`ALU_DATA_W);

   logic [msb:0]        opA;
   logic [msb:0]        opB;
   logic [shiftW-1:0]   shAmt;     // Barrel shift distance
   logic                carryQ;    // Machine status carry
   logic                invA;      // Subtract forms use ~a
   logic                carryIn;
   logic [msb:0]        addX;
   logic [`ALU_DATA_W:0] addSum;   // Carry out in top bit
   logic                cmpGt;
   logic [msb:0]        resWord;
   logic                carryNext;
   byteSelT             laneSel;

   assign opA   = issOp_i.a;
   assign opB   = issOp_i.b;
   assign shAmt = opB[shiftW-1:0];

   assign issTake_o = issValid_i && exReady_i;

   // Adder input selection
   always_comb begin
      invA = issOp_i.kind inside {RSUB, RSUBC, CMP, CMPU};
      case (issOp_i.kind)
         ADDC, RSUBC:     carryIn = carryQ;
         RSUB, CMP, CMPU: carryIn = 1'b1;   // Two's complement of a
         default:         carryIn = 1'b0;   // ADD and ADDR
      endcase
   end

   // One adder serves arithmetic, compare and address generation
   assign addX   = invA ? ~opA : opA;
   assign addSum = {1'b0, opB} + {1'b0, addX} + {{`ALU_DATA_W{1'b0}}, carryIn};

   assign cmpGt = (issOp_i.kind == CMPU) ? (opA > opB) : ($signed(opA) > $signed(opB));

   // Result word and next carry
   always_comb begin
      resWord   = addSum[msb:0];   // ADD family and ADDR
      carryNext = carryQ;          // Most kinds leave it alone
      case (issOp_i.kind)
         ADD, ADDC, RSUB, RSUBC: carryNext = addSum[`ALU_DATA_W];
         CMP, CMPU:              resWord = {cmpGt, addSum[msb-1:0]};   // Sign bit replaced
         OR:                     resWord = opA | opB;
         AND:                    resWord = opA & opB;
         XOR:                    resWord = opA ^ opB;
         ANDN:                   resWord = opA & ~opB;
         SRA: begin
            resWord   = {opA[msb], opA[msb:1]};
            carryNext = opA[0];
         end
         SRC: begin
            resWord   = {carryQ, opA[msb:1]};   // Old carry shifts in
            carryNext = opA[0];
         end
         SRL: begin
            resWord   = {1'b0, opA[msb:1]};
            carryNext = opA[0];
         end
         SEXT8:  resWord = {{(`ALU_DATA_W - 8){opA[7]}}, opA[7:0]};
         SEXT16: resWord = {{(`ALU_DATA_W - 16){opA[15]}}, opA[15:0]};
         BSRL:   resWord = opA >> shAmt;
         BSRA:   resWord = $unsigned($signed(opA) >>> shAmt);
         BSLL:   resWord = opA << shAmt;
         default: begin
         end
      endcase
   end

   // Big-endian lane enables from the low address bits
   always_comb begin
      laneSel = 4'h0;
      if (issOp_i.kind == ADDR) begin
         case (issOp_i.size)
            BYTE:    laneSel = 4'h8 >> addSum[1:0];   // Offset 0 is lane 3
            HALF:    laneSel = addSum[1] ? 4'h3 : 4'hC;
            WORD:    laneSel = 4'hF;
            default: laneSel = 4'h0;
         endcase
      end
   end

   // Control and carry, updated on the take edge so chained ops see it in order
   always_ff @(posedge clk_i) begin
      if (rst_i) begin
         exValid_o <= 1'b0;
         carryQ    <= 1'b0;
      end else begin
         exValid_o <= issTake_o;
         if (issTake_o) begin
            carryQ <= carryNext;
         end
      end
   end

   // Result register
   always_ff @(posedge clk_i) begin
      if (issTake_o) begin
         exRes_o <= '{data: resWord, carry: carryNext, byteSel: laneSel};
      end
   end

endmodule

`default_nettype wire

// File: source/result_stage.sv
//**********************************************************************
// Output side of the execute stage
// Result buffer, consumer credit counter, back-pressure toward exec_unit
//**********************************************************************

`timescale 1ns/1ns
`default_nettype none

`include "alu_settings.svh"

module result_stage (
   input  logic                   clk_i,
   input  logic                   rst_i,
   // From exec_unit
   input  alu_res_pkg::aluResT    exRes_i,
   input  logic                   exValid_i,
   output logic                   exReady_o,
   // Consumer side
   output logic                   resValid_o,
   output logic [`ALU_DATA_W-1:0] resData_o,
   output logic                   resCarry_o,
   output alu_res_pkg::byteSelT   resByteSel_o,
   input  logic                   resCredit_i
);

   import alu_res_pkg::*;

   aluResT                  headRes;
   logic                    bufEmpty;
   logic                    bufFull;
   logic                    bufAlmostFull;
   logic [`ALU_CREDIT_W-1:0] creditCnt;   // Free slots at the consumer

   credit_fifo #(
      .payloadT (aluResT),
      .DEPTH    (`ALU_RES_DEPTH)
   ) resBuf (
      .clk_i        (clk_i),
      .rst_i        (rst_i),
      .wrEn_i       (exValid_i),
      .wrData_i     (exRes_i),
      .rdEn_i       (resValid_o),
      .rdData_o     (headRes),
      .empty_o      (bufEmpty),
      .full_o       (bufFull),
      .almostFull_o (bufAlmostFull)
   );

   // Hold exec_unit off while the in-flight result would take the last slot
   assign exReady_o = !(bufFull || (bufAlmostFull && exValid_i));

   // Send one result per cycle while credits remain
   assign resValid_o   = !bufEmpty && (creditCnt != '0);
   assign resData_o    = headRes.data;
   assign resCarry_o   = headRes.carry;
   assign resByteSel_o = headRes.byteSel;

   always_ff @(posedge clk_i) begin
      if (rst_i) begin
         creditCnt <= `ALU_CREDIT_W'(`ALU_RES_CREDITS);
      end else begin
         creditCnt <= creditCnt - `ALU_CREDIT_W'(resValid_o)
                                + `ALU_CREDIT_W'(resCredit_i);   // Spend and refill together
      end
   end

endmodule

`default_nettype wire

// File: source/alu_top.sv
//**********************************************************************
// Execute stage top level
// Issue queue, execute datapath and result buffer in a chain
//**********************************************************************

`timescale 1ns/1ns
`default_nettype none

`include "alu_settings.svh"

module alu_top (
   input  logic                   clk_i,
   input  logic                   rst_i,
   // Operation input, credit controlled
   input  logic                   opValid_i,
   input  alu_op_pkg::opKindT     opKind_i,
   input  logic [`ALU_DATA_W-1:0] opA_i,
   input  logic [`ALU_DATA_W-1:0] opB_i,
   input  alu_op_pkg::accSizeT    opSize_i,
   output logic                   opCredit_o,
   // Result output, credit controlled
   output logic                   resValid_o,
   output logic [`ALU_DATA_W-1:0] resData_o,
   output logic                   resCarry_o,
   output alu_res_pkg::byteSelT   resByteSel_o,
   input  logic                   resCredit_i
);

   import alu_op_pkg::*;
   import alu_res_pkg::*;

   aluOpT  issOp;      // Queue head
   logic   issValid;
   logic   issTake;
   aluResT exOp;       // Registered result
   logic   exValid;
   logic   exReady;

   issue_stage issueStage (
      .clk_i      (clk_i),
      .rst_i      (rst_i),
      .opValid_i  (opValid_i),
      .opKind_i   (opKind_i),
      .opA_i      (opA_i),
      .opB_i      (opB_i),
      .opSize_i   (opSize_i),
      .opCredit_o (opCredit_o),
      .issOp_o    (issOp),
      .issValid_o (issValid),
      .issTake_i  (issTake)
   );

   exec_unit execUnit (
      .clk_i      (clk_i),
      .rst_i      (rst_i),
      .issOp_i    (issOp),
      .issValid_i (issValid),
      .issTake_o  (issTake),
      .exReady_i  (exReady),
      .exRes_o    (exOp),
      .exValid_o  (exValid)
   );

   result_stage resultStage (
      .clk_i        (clk_i),
      .rst_i        (rst_i),
      .exRes_i      (exOp),
      .exValid_i    (exValid),
      .exReady_o    (exReady),
      .resValid_o   (resValid_o),
      .resData_o    (resData_o),
      .resCarry_o   (resCarry_o),
      .resByteSel_o (resByteSel_o),
      .resCredit_i  (resCredit_i)
   );

endmodule

`default_nettype wire

// File: sim/alu_props.sv
//**********************************************************************
// Concurrent checks on the execute stage outputs
// Reset state, byte lane patterns, consumer credit bound, known values
//**********************************************************************

`timescale 1ns/1ns
`default_nettype none

`include "alu_settings.svh"

module alu_props (
   input logic                   clk_i,
   input logic                   rst_i,
   input logic                   opCredit_o,
   input logic                   resValid_o,
   input logic [`ALU_DATA_W-1:0] resData_o,
   input logic                   resCarry_o,
   input alu_res_pkg::byteSelT   resByteSel_o,
   input logic                   resCredit_i
);

   int stallRun;   // Valid cycles since the last credit back

   always_ff @(posedge clk_i) begin
      if (rst_i) begin
         stallRun <= 0;
      end else if (resCredit_i) begin
         stallRun <= 0;
      end else if (resValid_o) begin
         stallRun <= stallRun + 1;
      end
   end

   resetQuiet: assert property (@(posedge clk_i) rst_i |=> !resValid_o && !opCredit_o)
      else $error("Result valid or producer credit active right after reset");

   laneLegal: assert property (@(posedge clk_i) disable iff (rst_i)
      resValid_o |-> resByteSel_o inside {4'h0, 4'h1, 4'h2, 4'h4, 4'h8, 4'h3, 4'hC, 4'hF})
      else $error("Illegal byte lane pattern on a valid result");

   creditBound: assert property (@(posedge clk_i) disable iff (rst_i)
      resValid_o |-> stallRun < `ALU_RES_CREDITS)
      else $error("Results sent beyond the consumer credit count");

   knownOut: assert property (@(posedge clk_i) disable iff (rst_i)
      resValid_o |-> !$isunknown({resData_o, resCarry_o, resByteSel_o}))
      else $error("Unknown value on a valid result");

endmodule

bind alu_top alu_props aluProps (
   .clk_i        (clk_i),
   .rst_i        (rst_i),
   .opCredit_o   (opCredit_o),
   .resValid_o   (resValid_o),
   .resData_o    (resData_o),
   .resCarry_o   (resCarry_o),
   .resByteSel_o (resByteSel_o),
   .resCredit_i  (resCredit_i)
);

`default_nettype wire

// File: sim/alu_tb.sv
//**********************************************************************
// Testbench for the credit-controlled execute stage
// Clock and reset, reference model, producer with credit tracking,
// result collector, six directed tests, watchdog and closing report
//**********************************************************************

`timescale 1ns/1ns
`default_nettype none

`include "alu_settings.svh"

module alu_tb;

   import alu_op_pkg::*;

   localparam int numTests   = 6;
   localparam int halfPeriod = 50;     // 100 ns clock
   localparam int testCycles = 2000;   // Watchdog budget per test

   logic                   clk_i;
   logic                   rst_i;
   logic                   opValid_i;
   opKindT                 opKind_i;
   logic [`ALU_DATA_W-1:0] opA_i;
   logic [`ALU_DATA_W-1:0] opB_i;
   accSizeT                opSize_i;
   logic                   opCredit_o;
   logic                   resValid_o;
   logic [`ALU_DATA_W-1:0] resData_o;
   logic                   resCarry_o;
   logic [3:0]             resByteSel_o;
   logic                   resCredit_i = 1'b0;

   logic [36:0] expQ [$];          // Expected {data, carry, byteSel}
   string       testName = "reset";
   int          errCount = 0;
   int          opsSent = 0;
   int          creditsBack = 0;    // opCredit_o pulses seen
   int          resCount = 0;
   int          pendCredits = 0;    // Consumer credits still owed
   logic        holdCredits = 1'b0;
   logic        modelCarry = 1'b0;  // Carry as the model sees it
   int          seed = 32'h443a_874d;

   alu_top alu_top_i (
      .clk_i        (clk_i),
      .rst_i        (rst_i),
      .opValid_i    (opValid_i),
      .opKind_i     (opKind_i),
      .opA_i        (opA_i),
      .opB_i        (opB_i),
      .opSize_i     (opSize_i),
      .opCredit_o   (opCredit_o),
      .resValid_o   (resValid_o),
      .resData_o    (resData_o),
      .resCarry_o   (resCarry_o),
      .resByteSel_o (resByteSel_o),
      .resCredit_i  (resCredit_i)
   );

   initial begin
      clk_i = 1'b0;
      forever #(halfPeriod) clk_i = ~clk_i;
   end

   // Expected result from the instruction rules, {data, carry, byteSel}
   function automatic logic [36:0] refResult(input opKindT kind, input logic [31:0] a,
                                             input logic [31:0] b, input accSizeT size,
                                             input logic cin);
      logic [32:0] sum;
      logic [31:0] d;
      logic        c;
      logic [3:0]  sel;
      c   = cin;
      sel = 4'h0;
      d   = 32'h0;
      case (kind)
         ADD, ADDC: begin
            sum = {1'b0, a} + {1'b0, b} + {32'h0, kind == ADDC && cin};
            d   = sum[31:0];
            c   = sum[32];
         end
         RSUB, RSUBC: begin
            sum = {1'b0, b} + {1'b0, ~a} + {32'h0, kind == RSUB || cin};
            d   = sum[31:0];
            c   = sum[32];
         end
         CMP, CMPU: begin
            d = b - a;
            d[31] = (kind == CMP) ? ($signed(a) > $signed(b)) : (a > b);
         end
         OR:     d = a | b;
         AND:    d = a & b;
         XOR:    d = a ^ b;
         ANDN:   d = a & ~b;
         SRA, SRC, SRL: begin
            d = a >> 1;
            d[31] = (kind == SRA) ? a[31] : ((kind == SRC) ? cin : 1'b0);
            c = a[0];
         end
         SEXT8:  d = {{24{a[7]}}, a[7:0]};
         SEXT16: d = {{16{a[15]}}, a[15:0]};
         BSRL:   d = a >> b[4:0];
         BSRA:   d = a[31] ? ((a >> b[4:0]) | ~(32'hFFFF_FFFF >> b[4:0])) : (a >> b[4:0]);
         BSLL:   d = a << b[4:0];
         ADDR: begin
            d = a + b;
            if (size == WORD) begin
               sel = 4'hF;
            end else if (size == HALF) begin
               sel = d[1] ? 4'h3 : 4'hC;
            end else begin
               case (d[1:0])   // Big-endian, offset 0 is the top lane
                  2'd0:    sel = 4'h8;
                  2'd1:    sel = 4'h4;
                  2'd2:    sel = 4'h2;
                  default: sel = 4'h1;
               endcase
            end
         end
         default: d = 32'h0;
      endcase
      return {d, c, sel};
   endfunction

   task automatic checkValue(input string name, input logic [63:0] expVal,
                             input logic [63:0] actVal);
      if (expVal !== actVal) begin
         errCount++;
         $display("Fail %s: expected %h, actual %h", name, expVal, actVal);
      end
   endtask

   // Called on a falling edge, returns on the next one
   task automatic sendOp(input opKindT kind, input logic [31:0] a, input logic [31:0] b,
                         input accSizeT size);
      logic [36:0] expVal;
      while (opsSent - creditsBack >= `ALU_OP_DEPTH) begin
         @(negedge clk_i);   // No producer credit left
      end
      if (creditsBack > opsSent) begin
         errCount++;
         $display("Error in %s: more producer credits came back than ops sent", testName);
      end
      opValid_i  = 1'b1;
      opKind_i   = kind;
      opA_i      = a;
      opB_i      = b;
      opSize_i   = size;
      expVal     = refResult(kind, a, b, size, modelCarry);
      modelCarry = expVal[4];
      expQ.push_back(expVal);
      opsSent++;
      @(negedge clk_i);
      opValid_i = 1'b0;
   endtask

   task automatic waitDrain();
      while (expQ.size() != 0) begin
         @(negedge clk_i);
      end
      repeat (3) @(negedge clk_i);   // Let owed credits go back
   endtask

   // Producer credit returns
   always @(posedge clk_i) begin
      if (!rst_i && opCredit_o) begin
         creditsBack++;
      end
   end

   // Collector and consumer credit return
   always @(negedge clk_i) begin
      logic [36:0] expVal;
      if (!rst_i) begin
         if (resValid_o) begin
            resCount++;
            pendCredits++;
            if (expQ.size() == 0) begin
               errCount++;
               $display("Error in %s: a result arrived with nothing expected", testName);
            end else begin
               expVal = expQ.pop_front();
               checkValue(testName, 64'(expVal), 64'({resData_o, resCarry_o, resByteSel_o}));
            end
         end
         if (!holdCredits && pendCredits > 0) begin
            resCredit_i <= 1'b1;
            pendCredits--;
         end else begin
            resCredit_i <= 1'b0;
         end
      end
   end

   task automatic arithCarryTest();
      testName = "arith";
      sendOp(ADDC, 32'd5, 32'd7, WORD);          // Carry is 0 out of reset
      sendOp(ADD, 32'hFFFF_FFFF, 32'd1, WORD);   // Sets carry
      sendOp(ADDC, 32'd1, 32'd2, WORD);          // Chained carry in
      sendOp(RSUB, 32'd3, 32'd10, WORD);
      sendOp(RSUBC, 32'd10, 32'd3, WORD);        // Borrow clears carry
      sendOp(RSUBC, 32'd1, 32'd1, WORD);
      for (int i = 0; i < 12; i++) begin
         sendOp(opKindT'(i % 4), $random(seed), $random(seed), WORD);
      end
      waitDrain();
   endtask

   task automatic compareTest();
      testName = "compare";
      sendOp(CMP, 32'hFFFF_FFFF, 32'd1, WORD);   // -1 vs 1
      sendOp(CMP, 32'd5, 32'hFFFF_FFFD, WORD);   // 5 vs -3
      sendOp(CMPU, 32'hFFFF_FFFF, 32'd1, WORD);
      sendOp(CMPU, 32'd5, 32'hFFFF_FFFD, WORD);
      sendOp(ADD, 32'hFFFF_FFFF, 32'd1, WORD);   // Carry set, compares keep it
      for (int i = 0; i < 8; i++) begin
         sendOp((i % 2 == 0) ? CMP : CMPU, $random(seed), $random(seed), WORD);
      end
      waitDrain();
   endtask

   task automatic logicShiftTest();
      testName = "logic";
      for (int i = 0; i < 8; i++) begin
         sendOp(opKindT'(OR + i % 4), $random(seed), $random(seed), WORD);
      end
      sendOp(SRA, 32'h8000_0002, 32'd0, WORD);   // Sign fill, carry 1 to 0
      sendOp(SRC, 32'h0000_0011, 32'd0, WORD);   // Old carry 0 shifts in
      sendOp(SRC, 32'h0000_0010, 32'd0, WORD);   // Old carry 1 shifts in
      sendOp(SRL, 32'hF000_0001, 32'd0, WORD);   // Zero fill, carry 0 to 1
      sendOp(SEXT8, 32'h1234_5680, 32'd0, WORD);
      sendOp(SEXT8, 32'h1234_567F, 32'd0, WORD);
      sendOp(SEXT16, 32'h1234_8001, 32'd0, WORD);
      sendOp(SEXT16, 32'hABCD_7FFF, 32'd0, WORD);
      waitDrain();
   endtask

   task automatic barrelShiftTest();
      testName = "barrel";
      for (int i = 0; i < 15; i++) begin
         sendOp(opKindT'(BSRL + i % 3), $random(seed), $random(seed), WORD);
      end
      waitDrain();
   endtask

   task automatic addrGenTest();
      logic [31:0] base;
      testName = "addr";
      sendOp(ADD, 32'hFFFF_FFFF, 32'd1, WORD);   // Carry 1, ADDR must hold it
      for (int off = 0; off < 4; off++) begin
         base = $random(seed) & 32'hFFFF_FFF0;
         sendOp(ADDR, base, 32'(off), BYTE);
         sendOp(ADDR, base, 32'(off), HALF);
         sendOp(ADDR, base, 32'(off), WORD);
      end
      sendOp(ADD, 32'd8, 32'd3, BYTE);           // Size ignored, lanes stay 0
      waitDrain();
   endtask

   task automatic backPressureTest();
      int startCount;
      testName    = "backpressure";
      startCount  = resCount;
      holdCredits = 1'b1;
      fork
         begin
            for (int i = 0; i < 12; i++) begin
               sendOp(ADD, $random(seed), $random(seed), WORD);
            end
         end
         begin
            repeat (80) @(negedge clk_i);
            if (resCount - startCount > `ALU_RES_CREDITS) begin
               errCount++;
               $display("Error in %s: more results than consumer credits", testName);
            end
            holdCredits = 1'b0;
         end
      join
      waitDrain();
      checkValue(testName, 64'(12), 64'(resCount - startCount));
   endtask

   initial begin
      rst_i     = 1'b1;
      opValid_i = 1'b0;
      opKind_i  = ADD;
      opA_i     = '0;
      opB_i     = '0;
      opSize_i  = WORD;
      repeat (10) @(negedge clk_i);
      rst_i = 1'b0;
      @(negedge clk_i);
      arithCarryTest();
      compareTest();
      logicShiftTest();
      barrelShiftTest();
      addrGenTest();
      backPressureTest();
      $display("Errors: %0d", errCount);
      if (errCount == 0) begin
         $display("ALL CHECKS PASSED");
      end else begin
         $display("CHECKS FAILED");
      end
      $finish;
   end

   // Watchdog
   initial begin
      repeat (numTests * testCycles) @(posedge clk_i);
      $display("Timeout: tests did not finish within %0d cycles", numTests * testCycles);
      $display("Errors: %0d", errCount);
      $display("CHECKS FAILED");
      $finish;
   end

endmodule

`default_nettype wire

// File: filelist.f
+incdir+include
source/alu_op_pkg.sv
source/alu_res_pkg.sv
source/credit_fifo.sv
source/issue_stage.sv
source/exec_unit.sv
source/result_stage.sv
source/alu_top.sv
sim/alu_props.sv
sim/alu_tb.sv

// File: run_sim.sh
#!/bin/sh
# Build and run the execute stage testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -f filelist.f --top-module alu_tb -o alu_sim
if [ $? -ne 0 ]; then
   echo "Verilator build failed"
   exit 1
fi

./obj_dir/alu_sim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
   echo "Simulation exited with status $status"
   exit 1
fi

if grep -qx "ALL CHECKS PASSED" "$LOG"; then
   exit 0
fi
echo "Pass message not found in $LOG"
exit 1
